/* verilog.f */
verilog/egress_q_pkg.sv
verilog/pkt_stream_if.sv
verilog/egress_ctrl.sv
verilog/buffer_free_list.sv
verilog/buffer_ram.sv
verilog/pkt_buffer_writer.sv
verilog/desc_fifo.sv
verilog/pkt_buffer_reader.sv
verilog/egress_q_top.sv
test/egress_q_checker.sv
test/egress_q_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := egress_q_tb
FILELIST  := verilog.f
RUNFLAGS  := +verilator+error+limit+1000
PASS_MSG  := NO ERRORS
BIN       := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$($(BIN) $(RUNFLAGS))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

/* test/egress_q_tb.sv */
// Self-checking testbench for the egress packet queue.
// A scoreboard of accepted input words checks every output transfer.
// Uses the package default sizes for the DUT.

`timescale 1ns/1ps

module egress_q_tb
    import egress_q_pkg::*;
();

    // Phases send 16, 16, NUM_BUFFERS+4, 4, 1 and 3 packets
    localparam int TOTAL_PKTS     = 60;
    // Up to 8 cycles per word under heavy back-pressure, plus the resets
    localparam int TIMEOUT_CYCLES = TOTAL_PKTS * BUFFER_WORDS * 8 + 160;
    localparam int STALL_CYCLES   = 4 * BUFFER_WORDS;
    // One cycle for the reset register, then one per pointer
    localparam int INIT_CYCLES    = NUM_BUFFERS + 1;
    localparam int RDY_HIGH       = 0;
    localparam int RDY_RAND       = 1;
    localparam int RDY_LOW        = 2;

    typedef struct packed {
        logic [PORT_WID-1:0] dest;
        logic                last;
        logic [DATA_WID-1:0] data;
    } word_t;

    logic                clk;
    logic                i_rst_n, i_enable, i_soft_rst;
    logic                i_tvalid, i_tlast, o_tready;
    logic [DATA_WID-1:0] i_tdata, o_tdata;
    logic [PORT_WID-1:0] i_tdest, o_tdest;
    logic                i_tready = 1'b0;
    logic                o_tvalid, o_tlast, o_init_done;

    word_t  sb [$];
    int     errors    = 0;
    int     pkts_in   = 0;
    int     cycle_cnt = 0;
    int     rdy_mode  = RDY_HIGH;
    integer seed      = 32'hc505;
    integer rdy_seed  = 32'hc505 ^ 32'h0000_ffff;

    egress_q_top #(
        .DATA_WID(DATA_WID), .NUM_BUFFERS(NUM_BUFFERS), .BUFFER_WORDS(BUFFER_WORDS)
    ) dut0 (
        .clk (clk), .i_rst_n (i_rst_n), .i_enable (i_enable), .i_soft_rst (i_soft_rst),
        .i_tvalid (i_tvalid), .o_tready (o_tready), .i_tdata (i_tdata),
        .i_tlast (i_tlast), .i_tdest (i_tdest),
        .o_tvalid (o_tvalid), .i_tready (i_tready), .o_tdata (o_tdata),
        .o_tlast (o_tlast), .o_tdest (o_tdest), .o_init_done (o_init_done)
    );

    bind egress_q_top egress_q_checker #(.DATA_WID(DATA_WID)) u_chk (
        .clk (clk), .i_rst_n (i_rst_n), .i_enable (i_enable), .local_rst (local_rst),
        .o_tvalid (o_tvalid), .i_tready (i_tready), .o_tdata (o_tdata),
        .o_tlast (o_tlast), .o_tdest (o_tdest), .o_tready (o_tready),
        .o_init_done (o_init_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_equal(input string name, input logic [63:0] exp, act);
        assert (exp == act) else begin
            $display("Fail %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // Sink ready and scoreboard monitor
    // --------------------------------------------------
    always @(negedge clk) begin
        case (rdy_mode)
            RDY_HIGH: i_tready = 1'b1;
            RDY_RAND: i_tready = 1'($random(rdy_seed));
            default:  i_tready = 1'b0;
        endcase
    end

    always @(posedge clk) begin
        word_t exp_word;
        if (i_tvalid && o_tready) begin
            sb.push_back({i_tdest, i_tlast, i_tdata});
            if (i_tlast) pkts_in++;
        end
        if (o_tvalid && i_tready) begin
            if (sb.size() == 0) begin
                $display("Output word appeared with no input word left to match it");
                errors++;
            end else begin
                exp_word = sb.pop_front();
                check_equal("o_tdata", 64'(exp_word.data), 64'(o_tdata));
                check_equal("o_tlast", 64'(exp_word.last), 64'(o_tlast));
                check_equal("o_tdest", 64'(exp_word.dest), 64'(o_tdest));
            end
        end
        // Bypass is a pure comb path
        if (!i_enable) begin
            check_equal("o_tvalid", 64'(i_tvalid), 64'(o_tvalid));
            check_equal("o_tready", 64'(i_tready), 64'(o_tready));
            check_equal("o_tdata", 64'(i_tdata), 64'(o_tdata));
        end
    end

    // --------------------------------------------------
    // Stimulus tasks, all start and end on a falling edge
    // --------------------------------------------------
    task automatic send_packet(input int len, input logic [PORT_WID-1:0] dest);
        int i;
        for (i = 0; i < len; i++) begin
            i_tvalid = 1'b1;
            i_tdata  = DATA_WID'($random(seed));
            i_tlast  = (i == len - 1);
            i_tdest  = dest;
            @(posedge clk);
            while (!o_tready) @(posedge clk);
            @(negedge clk);
        end
        i_tvalid = 1'b0;
    endtask

    task automatic send_random_packets(input int num);
        int k;
        int len;
        for (k = 0; k < num; k++) begin
            len = 1 + ($unsigned($random(seed)) % BUFFER_WORDS);
            send_packet(len, PORT_WID'($random(seed)));
        end
    endtask

    task automatic wait_drain();
        while (sb.size() != 0) @(negedge clk);
        // Let the reader hand its last buffer back
        repeat (2) @(negedge clk);
    endtask

    task automatic wait_init_done();
        int cnt;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!o_init_done && cnt <= 4 * INIT_CYCLES);
        check_equal("o_init_done delay", 64'(INIT_CYCLES), 64'(cnt));
    endtask

    task automatic exhaust_buffers();
        int base;
        int low_cnt;
        base     = pkts_in;
        rdy_mode = RDY_LOW;
        fork
            send_random_packets(NUM_BUFFERS + 4);
            begin
                low_cnt = 0;
                while (low_cnt < STALL_CYCLES) begin
                    @(negedge clk);
                    low_cnt = (i_tvalid && !o_tready) ? low_cnt + 1 : 0;
                end
                check_equal("stored packets", 64'(NUM_BUFFERS), 64'(pkts_in - base));
                rdy_mode = RDY_HIGH;
            end
        join
    endtask

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, traffic did not complete", cycle_cnt);
        $display("Closing: %0d scoreboard errors, %0d assertion errors", errors,
                 dut0.u_chk.fail_cnt);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        i_rst_n    = 1'b0;
        i_enable   = 1'b1;
        i_soft_rst = 1'b0;
        i_tvalid   = 1'b0;
        i_tdata    = '0;
        i_tlast    = 1'b0;
        i_tdest    = '0;
        repeat (2) @(negedge clk);
        i_rst_n = 1'b1;
        check_equal("o_tvalid", 64'(0), 64'(o_tvalid));
        check_equal("o_init_done", 64'(0), 64'(o_init_done));
        wait_init_done();

        send_random_packets(16);
        wait_drain();
        rdy_mode = RDY_RAND;
        send_random_packets(16);
        wait_drain();
        exhaust_buffers();
        wait_drain();

        i_enable = 1'b0;
        rdy_mode = RDY_RAND;
        send_random_packets(4);
        wait_drain();
        i_enable = 1'b1;

        // Hard reset while a stored word waits at the stalled output
        rdy_mode = RDY_LOW;
        send_random_packets(1);
        while (!o_tvalid) @(negedge clk);
        i_rst_n = 1'b0;
        repeat (2) @(negedge clk);
        i_rst_n = 1'b1;
        sb.delete();
        rdy_mode = RDY_RAND;
        wait_init_done();

        sb.delete();
        i_soft_rst = 1'b1;
        @(negedge clk);
        i_soft_rst = 1'b0;
        wait_init_done();
        send_random_packets(3);
        wait_drain();

        $display("Closing: %0d scoreboard errors, %0d assertion errors", errors,
                 dut0.u_chk.fail_cnt);
        if (errors == 0 && dut0.u_chk.fail_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* test/egress_q_checker.sv */
// Concurrent protocol checks on the egress queue top level.
// Bound into egress_q_top, so local_rst is the DUT's registered reset.

`timescale 1ns/1ps

module egress_q_checker
    import egress_q_pkg::*;
#(
    parameter int DATA_WID = egress_q_pkg::DATA_WID
) (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_enable,
    input  logic                local_rst,
    input  logic                o_tvalid,
    input  logic                i_tready,
    input  logic [DATA_WID-1:0] o_tdata,
    input  logic                o_tlast,
    input  logic [PORT_WID-1:0] o_tdest,
    input  logic                o_tready,
    input  logic                o_init_done
);

    int unsigned fail_cnt = 0;

    // A stalled output word holds until it is taken
    a_out_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast)
            && $stable(o_tdest))
    else begin
        $error("output word changed or dropped while the sink stalled");
        fail_cnt++;
    end

    // No input is taken before the free list is loaded
    a_ready_before_init: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_enable && !o_init_done |-> !o_tready)
    else begin
        $error("o_tready high in queue mode before o_init_done");
        fail_cnt++;
    end

    a_no_valid_in_reset: assert property (@(posedge clk)
        i_enable && local_rst |=> !o_tvalid)
    else begin
        $error("o_tvalid high after a local reset cycle");
        fail_cnt++;
    end

endmodule

/* verilog/egress_q_top.sv */
// Egress packet queue, single port.
// Packets up to BUFFER_WORDS words, stored one per buffer.
// i_enable low routes the input straight to the output.
// o_init_done rises NUM_BUFFERS cycles after the local reset ends.

`timescale 1ns/1ps

module egress_q_top
    import egress_q_pkg::*;
#(
    parameter int DATA_WID     = egress_q_pkg::DATA_WID,
    parameter int NUM_BUFFERS  = egress_q_pkg::NUM_BUFFERS,
    parameter int BUFFER_WORDS = egress_q_pkg::BUFFER_WORDS
) (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_enable,
    input  logic                i_soft_rst,
    input  logic                i_tvalid,
    output logic                o_tready,
    input  logic [DATA_WID-1:0] i_tdata,
    input  logic                i_tlast,
    input  logic [PORT_WID-1:0] i_tdest,
    output logic                o_tvalid,
    input  logic                i_tready,
    output logic [DATA_WID-1:0] o_tdata,
    output logic                o_tlast,
    output logic [PORT_WID-1:0] o_tdest,
    output logic                o_init_done
);

    localparam int ADDR_WID = $bits(ptr_t) + $clog2(BUFFER_WORDS);

    logic                local_rst, ptr_pop, ptr_empty, ptr_push;
    ptr_t                free_ptr, ret_ptr;
    logic                wr_en;
    logic [ADDR_WID-1:0] wr_addr, rd_addr;
    logic [DATA_WID-1:0] wr_data, rd_data;
    logic                desc_push, desc_pop, desc_empty, desc_full;
    desc_t               desc_in, desc_out;

    pkt_stream_if #(.DATA_WID(DATA_WID)) s_in_if ();
    pkt_stream_if #(.DATA_WID(DATA_WID)) q_in_if ();
    pkt_stream_if #(.DATA_WID(DATA_WID)) q_out_if ();
    pkt_stream_if #(.DATA_WID(DATA_WID)) s_out_if ();

    // --------------------------------------------------
    // Plain ports onto the stream bundles
    // --------------------------------------------------
    assign s_in_if.tvalid  = i_tvalid;
    assign s_in_if.tdata   = i_tdata;
    assign s_in_if.tlast   = i_tlast;
    assign s_in_if.tdest   = i_tdest;
    assign o_tready        = s_in_if.tready;
    assign o_tvalid        = s_out_if.tvalid;
    assign o_tdata         = s_out_if.tdata;
    assign o_tlast         = s_out_if.tlast;
    assign o_tdest         = s_out_if.tdest;
    assign s_out_if.tready = i_tready;

    egress_ctrl u_ctrl (
        .clk, .i_rst_n, .i_soft_rst, .i_enable,
        .o_local_rst (local_rst),
        .s_in (s_in_if), .q_in (q_in_if), .q_out (q_out_if), .s_out (s_out_if)
    );

    buffer_free_list #(.NUM_BUFFERS(NUM_BUFFERS)) u_free (
        .clk, .i_rst (local_rst),
        .i_pop (ptr_pop), .o_ptr (free_ptr), .o_empty (ptr_empty),
        .i_push (ptr_push), .i_ptr (ret_ptr), .o_init_done
    );

    buffer_ram #(
        .DATA_WID(DATA_WID), .NUM_BUFFERS(NUM_BUFFERS), .BUFFER_WORDS(BUFFER_WORDS)
    ) u_ram (
        .clk, .i_wr_en (wr_en), .i_wr_addr (wr_addr), .i_wr_data (wr_data),
        .i_rd_addr (rd_addr), .o_rd_data (rd_data)
    );

    pkt_buffer_writer #(.DATA_WID(DATA_WID), .BUFFER_WORDS(BUFFER_WORDS)) u_wr (
        .clk, .i_rst (local_rst), .i_init_done (o_init_done), .s_in (q_in_if),
        .o_ptr_pop (ptr_pop), .i_ptr (free_ptr), .i_ptr_empty (ptr_empty),
        .o_wr_en (wr_en), .o_wr_addr (wr_addr), .o_wr_data (wr_data),
        .o_desc_push (desc_push), .o_desc (desc_in), .i_desc_full (desc_full)
    );

    desc_fifo #(.DEPTH(NUM_BUFFERS)) u_fifo (
        .clk, .i_rst (local_rst), .i_push (desc_push), .i_desc (desc_in),
        .i_pop (desc_pop), .o_desc (desc_out), .o_empty (desc_empty), .o_full (desc_full)
    );

    pkt_buffer_reader #(.DATA_WID(DATA_WID), .BUFFER_WORDS(BUFFER_WORDS)) u_rd (
        .clk, .i_rst (local_rst),
        .i_desc_empty (desc_empty), .i_desc (desc_out), .o_desc_pop (desc_pop),
        .o_rd_addr (rd_addr), .i_rd_data (rd_data),
        .o_ptr_push (ptr_push), .o_ptr (ret_ptr), .s_out (q_out_if)
    );

endmodule

/* verilog/pkt_buffer_reader.sv */
// Streams stored packets out in descriptor order.
// Reads run ahead into a two-entry holding stage, one word per cycle.
// A buffer returns to the free list only after its last word has left.

`timescale 1ns/1ps

module pkt_buffer_reader
    import egress_q_pkg::*;
#(
    parameter int DATA_WID     = egress_q_pkg::DATA_WID,
    parameter int BUFFER_WORDS = egress_q_pkg::BUFFER_WORDS
) (
    input  logic                                         clk,
    input  logic                                         i_rst,
    input  logic                                         i_desc_empty,
    input  desc_t                                        i_desc,
    output logic                                         o_desc_pop,
    output logic [$bits(ptr_t)+$clog2(BUFFER_WORDS)-1:0] o_rd_addr,
    input  logic [DATA_WID-1:0]                          i_rd_data,
    output logic                                         o_ptr_push,
    output ptr_t                                         o_ptr,
    pkt_stream_if.tx                                     s_out
);

    localparam int OFF_WID = $clog2(BUFFER_WORDS);
    typedef logic [OFF_WID-1:0] off_t;

    rd_state_t           state;
    desc_t               cur_desc;
    off_t                rd_off;
    logic                at_last, rd_issue, rd_pend, pend_last, xfer;
    logic [DATA_WID-1:0] hold_data [2];
    logic                hold_last [2];
    logic                hold_wr, hold_rd;
    logic [1:0]          hold_cnt, occ;

    assign xfer         = s_out.tvalid && s_out.tready;
    assign s_out.tvalid = (hold_cnt != 2'd0);
    assign s_out.tdata  = hold_data[hold_rd];
    assign s_out.tlast  = hold_last[hold_rd];
    assign s_out.tdest  = cur_desc.dest;

    // Words held plus the read still in flight must fit in two entries
    assign occ      = hold_cnt + {1'b0, rd_pend};
    assign at_last  = (rd_off == off_t'(cur_desc.len));
    assign rd_issue = (state == RD_DATA) && ((occ < 2'd2) || xfer);
    assign o_rd_addr = {cur_desc.ptr, rd_off};

    assign o_desc_pop = (state == RD_IDLE) && !i_desc_empty;
    assign o_ptr_push = (state == RD_FREE) && (hold_cnt == 2'd0) && !rd_pend;
    assign o_ptr      = cur_desc.ptr;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state    <= RD_IDLE;
            rd_pend  <= 1'b0;
            hold_wr  <= 1'b0;
            hold_rd  <= 1'b0;
            hold_cnt <= 2'd0;
        end else begin
            rd_pend  <= rd_issue;
            hold_cnt <= hold_cnt + {1'b0, rd_pend} - {1'b0, xfer};
            if (rd_pend) hold_wr <= ~hold_wr;
            if (xfer)    hold_rd <= ~hold_rd;
            case (state)
                RD_IDLE: if (o_desc_pop) state <= RD_DATA;
                RD_DATA: if (rd_issue && at_last) state <= RD_FREE;
                RD_FREE: if (o_ptr_push) state <= RD_IDLE;
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_desc_pop) begin
            cur_desc <= i_desc;
            rd_off   <= '0;
        end else if (rd_issue) begin
            rd_off <= rd_off + 1'b1;
        end
        pend_last <= at_last;
        if (rd_pend) begin
            hold_data[hold_wr] <= i_rd_data;
            hold_last[hold_wr] <= pend_last;
        end
    end

endmodule

/* verilog/desc_fifo.sv */
// Register FIFO of packet descriptors, first word falls through.
// Pushes while full and pops while empty are ignored.
// DEPTH must be a power of two.

`timescale 1ns/1ps

module desc_fifo
    import egress_q_pkg::*;
#(
    parameter int DEPTH = egress_q_pkg::NUM_BUFFERS
) (
    input  logic  clk,
    input  logic  i_rst,
    input  logic  i_push,
    input  desc_t i_desc,
    input  logic  i_pop,
    output desc_t o_desc,
    output logic  o_empty,
    output logic  o_full
);

    localparam int IDX_WID = $clog2(DEPTH);

    desc_t              mem [DEPTH];
    logic [IDX_WID-1:0] rd_idx;
    logic [IDX_WID-1:0] wr_idx;
    logic [IDX_WID:0]   count;
    logic               do_push;
    logic               do_pop;

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;
    assign o_empty = (count == '0);
    assign o_full  = (count == (IDX_WID+1)'(DEPTH));
    assign o_desc  = mem[rd_idx];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            rd_idx <= '0;
            wr_idx <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_idx <= wr_idx + 1'b1;
            if (do_pop)  rd_idx <= rd_idx + 1'b1;
            count <= count + (IDX_WID+1)'(do_push) - (IDX_WID+1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_idx] <= i_desc;
    end

endmodule

/* verilog/pkt_buffer_writer.sv */
// Writes each input packet into one buffer and emits its descriptor.
// Packets must not exceed BUFFER_WORDS words; longer ones wrap in the buffer.
// The descriptor is pushed one cycle after the last word is written.

`timescale 1ns/1ps

module pkt_buffer_writer
    import egress_q_pkg::*;
#(
    parameter int DATA_WID     = egress_q_pkg::DATA_WID,
    parameter int BUFFER_WORDS = egress_q_pkg::BUFFER_WORDS
) (
    input  logic                                         clk,
    input  logic                                         i_rst,
    input  logic                                         i_init_done,
    pkt_stream_if.rx                                     s_in,
    output logic                                         o_ptr_pop,
    input  ptr_t                                         i_ptr,
    input  logic                                         i_ptr_empty,
    output logic                                         o_wr_en,
    output logic [$bits(ptr_t)+$clog2(BUFFER_WORDS)-1:0] o_wr_addr,
    output logic [DATA_WID-1:0]                          o_wr_data,
    output logic                                         o_desc_push,
    output desc_t                                        o_desc,
    input  logic                                         i_desc_full
);

    localparam int OFF_WID = $clog2(BUFFER_WORDS);
    typedef logic [OFF_WID-1:0] off_t;

    wr_state_t           state;
    ptr_t                cur_ptr;
    off_t                offset;
    logic [PORT_WID-1:0] first_dest;
    logic                xfer;

    // Grab a pointer only once the free list is loaded
    assign o_ptr_pop   = (state == WR_IDLE) && i_init_done && !i_ptr_empty;
    assign s_in.tready = (state == WR_DATA) && !i_desc_full;
    assign xfer        = s_in.tvalid && s_in.tready;

    assign o_wr_en   = xfer;
    assign o_wr_addr = {cur_ptr, offset};
    assign o_wr_data = s_in.tdata;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state       <= WR_IDLE;
            o_desc_push <= 1'b0;
        end else begin
            o_desc_push <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (o_ptr_pop) state <= WR_DATA;
                end
                WR_DATA: begin
                    if (xfer && s_in.tlast) begin
                        state       <= WR_IDLE;
                        o_desc_push <= 1'b1;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Buffer position and descriptor payload
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (o_ptr_pop) begin
            cur_ptr <= i_ptr;
            offset  <= '0;
        end else if (xfer) begin
            offset <= offset + 1'b1;
        end
        if (xfer && offset == '0) first_dest <= s_in.tdest;
        if (xfer && s_in.tlast) begin
            o_desc.ptr  <= cur_ptr;
            o_desc.len  <= len_t'(offset);
            o_desc.dest <= (offset == '0) ? s_in.tdest : first_dest;
        end
    end

endmodule

/* verilog/buffer_ram.sv */
// Simple dual-port word RAM for all packet buffers.
// Address is the buffer pointer followed by the word offset.
// Read data is registered and arrives one cycle after the address.

`timescale 1ns/1ps

module buffer_ram
    import egress_q_pkg::*;
#(
    parameter int DATA_WID     = egress_q_pkg::DATA_WID,
    parameter int NUM_BUFFERS  = egress_q_pkg::NUM_BUFFERS,
    parameter int BUFFER_WORDS = egress_q_pkg::BUFFER_WORDS
) (
    input  logic                                         clk,
    input  logic                                         i_wr_en,
    input  logic [$bits(ptr_t)+$clog2(BUFFER_WORDS)-1:0] i_wr_addr,
    input  logic [DATA_WID-1:0]                          i_wr_data,
    input  logic [$bits(ptr_t)+$clog2(BUFFER_WORDS)-1:0] i_rd_addr,
    output logic [DATA_WID-1:0]                          o_rd_data
);

    logic [DATA_WID-1:0] mem [NUM_BUFFERS*BUFFER_WORDS];

    always_ff @(posedge clk) begin
        if (i_wr_en) mem[i_wr_addr] <= i_wr_data;
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

/* verilog/buffer_free_list.sv */
// Circular FIFO of free buffer pointers.
// After reset it loads pointers 0 to NUM_BUFFERS-1, one per cycle, then
// raises o_init_done. Pops while empty are ignored.

`timescale 1ns/1ps

module buffer_free_list
    import egress_q_pkg::*;
#(
    parameter int NUM_BUFFERS = egress_q_pkg::NUM_BUFFERS
) (
    input  logic clk,
    input  logic i_rst,
    input  logic i_pop,
    output ptr_t o_ptr,
    output logic o_empty,
    input  logic i_push,
    input  ptr_t i_ptr,
    output logic o_init_done
);

    localparam int IDX_WID = $clog2(NUM_BUFFERS);

    ptr_t               mem [NUM_BUFFERS];
    logic [IDX_WID-1:0] rd_idx;
    logic [IDX_WID-1:0] wr_idx;
    logic [IDX_WID:0]   count;
    logic               filling;
    logic               do_push;
    logic               do_pop;

    // During the fill the write index is also the pointer value
    assign filling = !o_init_done;
    assign do_push = filling || i_push;
    assign do_pop  = i_pop && !o_empty;
    assign o_empty = (count == '0);
    assign o_ptr   = mem[rd_idx];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            rd_idx      <= '0;
            wr_idx      <= '0;
            count       <= '0;
            o_init_done <= 1'b0;
        end else begin
            if (do_push) wr_idx <= wr_idx + 1'b1;
            if (do_pop)  rd_idx <= rd_idx + 1'b1;
            count <= count + (IDX_WID+1)'(do_push) - (IDX_WID+1)'(do_pop);
            if (filling && wr_idx == IDX_WID'(NUM_BUFFERS - 1)) o_init_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_idx] <= filling ? ptr_t'(wr_idx) : i_ptr;
    end

endmodule

/* verilog/egress_ctrl.sv */
// Reset combining and bypass steering.
// The local reset follows i_rst_n or i_soft_rst one cycle later.
// i_enable may only change while no packet is partway through the queue.

`timescale 1ns/1ps

module egress_ctrl (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_soft_rst,
    input  logic        i_enable,
    output logic        o_local_rst,
    pkt_stream_if.rx    s_in,
    pkt_stream_if.tx    q_in,
    pkt_stream_if.rx    q_out,
    pkt_stream_if.tx    s_out
);

    always_ff @(posedge clk) begin
        o_local_rst <= !i_rst_n || i_soft_rst;
    end

    // --------------------------------------------------
    // Input side, queue or bypass
    // --------------------------------------------------
    assign q_in.tvalid = i_enable && s_in.tvalid;
    assign q_in.tdata  = s_in.tdata;
    assign q_in.tlast  = s_in.tlast;
    assign q_in.tdest  = s_in.tdest;
    assign s_in.tready = i_enable ? q_in.tready : s_out.tready;

    // --------------------------------------------------
    // Output side
    // --------------------------------------------------
    assign s_out.tvalid = i_enable ? q_out.tvalid : s_in.tvalid;
    assign s_out.tdata  = i_enable ? q_out.tdata  : s_in.tdata;
    assign s_out.tlast  = i_enable ? q_out.tlast  : s_in.tlast;
    assign s_out.tdest  = i_enable ? q_out.tdest  : s_in.tdest;
    assign q_out.tready = i_enable && s_out.tready;

endmodule

/* verilog/pkt_stream_if.sv */
// One packet stream with a valid/ready handshake.
// A word moves on a clock edge where tvalid and tready are both high.
// The sender keeps tvalid and the payload stable until that transfer.

`timescale 1ns/1ps

interface pkt_stream_if
    import egress_q_pkg::*;
#(
    parameter int DATA_WID = egress_q_pkg::DATA_WID
);

    logic                tvalid;
    logic                tready;
    logic [DATA_WID-1:0] tdata;
    logic                tlast;
    logic [PORT_WID-1:0] tdest;

    // Sender side
    modport tx (
        output tvalid, tdata, tlast, tdest,
        input  tready
    );

    // Receiver side
    modport rx (
        input  tvalid, tdata, tlast, tdest,
        output tready
    );

endinterface

/* verilog/egress_q_pkg.sv */
// Shared sizes and types for the egress packet queue.
// ptr_t and len_t are sized from the defaults below. Module parameters may
// be smaller powers of two than these defaults but not larger.
// BUFFER_WORDS must be at least 2.

package egress_q_pkg;

    localparam int DATA_WID     = 32;
    localparam int NUM_BUFFERS  = 16;
    localparam int BUFFER_WORDS = 8;
    localparam int PORT_WID     = 3;

    localparam int PTR_WID = $clog2(NUM_BUFFERS);
    localparam int LEN_WID = $clog2(BUFFER_WORDS);

    typedef logic [PTR_WID-1:0] ptr_t;

    // Packet length in words, minus one
    typedef logic [LEN_WID-1:0] len_t;

    typedef struct packed {
        ptr_t                ptr;
        len_t                len;
        logic [PORT_WID-1:0] dest;
    } desc_t;

    typedef enum logic {
        WR_IDLE,
        WR_DATA
    } wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_DATA,
        RD_FREE
    } rd_state_t;

endpackage
